// File: source/axi_read_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths and burst constants for the AXI4 read master
// Beat size, burst limits, counter widths and the 4 KB alignment
////////////////////////////////////////////////////////////////////////////

package axi_read_pkg;

  // Bus widths
  localparam int addr_width      = 32;
  localparam int data_width      = 32;
  localparam int xfer_size_width = 32;

  // Bytes per beat and the byte offset bits inside one beat
  localparam int dw_bytes     = data_width / 8;
  localparam int log_dw_bytes = $clog2(dw_bytes);

  // A burst may not cross 4 KB and may not exceed 256 beats
  localparam int max_burst_beats = (4096 / dw_bytes < 256) ? 4096 / dw_bytes : 256;
  localparam int log_burst_beats = $clog2(max_burst_beats);
  localparam int burst_bytes     = max_burst_beats * dw_bytes;

  // Beat count minus one, and its upper part as a burst index
  localparam int total_len_width  = xfer_size_width - log_dw_bytes;
  localparam int burst_cntr_width = total_len_width - log_burst_beats;

  // Bursts in flight between AR handshake and the last stream beat
  localparam int max_outstanding        = 4;
  localparam int outstanding_cntr_width = $clog2(max_outstanding + 1);

  // Low address bits forced to zero when the request is captured
  localparam int align_4k_mask_bits = 12;

endpackage : axi_read_pkg

// File: source/read_request_setup.sv
////////////////////////////////////////////////////////////////////////////
// Request capture for the AXI4 read master
// Rounds the byte count up to whole beats, aligns the address to 4 KB
// and splits the beat count into a burst index and a final arlen
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_request_setup
  import axi_read_pkg::*;
(
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        ctrl_start,
  input  logic [addr_width-1:0]       ctrl_addr_offset,
  input  logic [xfer_size_width-1:0]  ctrl_xfer_size_in_bytes,
  output logic                        burst_start,
  output logic [addr_width-1:0]       base_addr,
  output logic [burst_cntr_width-1:0] last_burst_index,
  output logic [log_burst_beats-1:0]  final_burst_len
);

  // Start delay line
  logic start_d1;

  // Captured request
  logic [total_len_width-1:0] total_len_r;
  logic [addr_width-1:0]      addr_aligned_r;

  // Beat count of the size and whether a partial beat is left over
  logic [total_len_width-1:0] size_beats;
  logic                       has_partial_beat;

  assign size_beats       = ctrl_xfer_size_in_bytes[log_dw_bytes +: total_len_width];
  assign has_partial_beat = |ctrl_xfer_size_in_bytes[log_dw_bytes-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Capture on ctrl_start
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Beats minus one in arlen style; a partial beat adds a whole beat
      if (has_partial_beat) begin
        total_len_r <= size_beats;
      end else begin
        total_len_r <= size_beats - 1'b1;
      end
      // Clear the low 12 bits so no burst crosses a 4 KB page
      addr_aligned_r <= {ctrl_addr_offset[addr_width-1:align_4k_mask_bits],
                         {align_4k_mask_bits{1'b0}}};
    end
  end

  // Two register stages between ctrl_start and burst_start
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1    <= 1'b0;
      burst_start <= 1'b0;
    end else begin
      start_d1    <= ctrl_start;
      burst_start <= start_d1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Burst split
  ////////////////////////////////////////////////////////////////////////////

  // Upper bits give bursts minus one, low bits the last burst's arlen
  assign last_burst_index = total_len_r[log_burst_beats +: burst_cntr_width];
  assign final_burst_len  = total_len_r[log_burst_beats-1:0];
  assign base_addr        = addr_aligned_r;

endmodule : read_request_setup

// File: source/ar_burst_issuer.sv
////////////////////////////////////////////////////////////////////////////
// AXI4 read address channel driver
// Walks the bursts of one request, stepping the address by one full
// burst per handshake and giving the last burst its short arlen
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ar_burst_issuer
  import axi_read_pkg::*;
(
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        burst_start,
  input  logic [addr_width-1:0]       base_addr,
  input  logic [burst_cntr_width-1:0] last_burst_index,
  input  logic [log_burst_beats-1:0]  final_burst_len,
  input  logic                        ar_stall,
  input  logic                        m_axi_arready,
  output logic                        m_axi_arvalid,
  output logic [addr_width-1:0]       m_axi_araddr,
  output logic [log_burst_beats-1:0]  m_axi_arlen,
  output logic                        ar_accepted
);

  // Issue state
  logic                        ar_idle;
  logic                        arvalid_r;
  logic [addr_width-1:0]       addr_r;
  logic [burst_cntr_width-1:0] bursts_to_go;
  logic                        ar_final_burst;
  logic                        ar_done;

  // Address handshake
  assign ar_accepted    = arvalid_r & m_axi_arready;
  assign ar_final_burst = (bursts_to_go == '0);
  assign ar_done        = ar_final_burst & ar_accepted;

  ////////////////////////////////////////////////////////////////////////////
  // Idle flag and arvalid
  ////////////////////////////////////////////////////////////////////////////

  // Leaves idle on burst_start, returns once the final address is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (burst_start) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // One idle cycle between handshakes, held off while stalled
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid_r <= 1'b0;
    end else if (!ar_idle && !ar_stall && !arvalid_r) begin
      arvalid_r <= 1'b1;
    end else if (m_axi_arready) begin
      arvalid_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and burst counter
  ////////////////////////////////////////////////////////////////////////////

  // Next burst starts one full burst further on
  always_ff @(posedge aclk) begin
    if (burst_start) begin
      addr_r <= base_addr;
    end else if (ar_accepted) begin
      addr_r <= addr_r + addr_width'(burst_bytes);
    end
  end

  // Bursts left to issue after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_go <= '0;
    end else if (burst_start) begin
      bursts_to_go <= last_burst_index;
    end else if (ar_accepted && !ar_final_burst) begin
      bursts_to_go <= bursts_to_go - 1'b1;
    end
  end

  assign m_axi_arvalid = arvalid_r;
  assign m_axi_araddr  = addr_r;
  // Full bursts carry 255, the last one the remainder
  assign m_axi_arlen   = ar_final_burst ? final_burst_len
                                        : log_burst_beats'(max_burst_beats - 1);

  // AR payload stays put until the slave takes it
  a_ar_hold : assert property (@(posedge aclk) disable iff (areset)
    (m_axi_arvalid && !m_axi_arready) |=>
      (m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen)));

endmodule : ar_burst_issuer

// File: source/r_completion_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Read completion tracking for the AXI4 read master
// Outstanding burst vacancy with AR stall, remaining bursts and done
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module r_completion_tracker
  import axi_read_pkg::*;
(
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        burst_start,
  input  logic [burst_cntr_width-1:0] last_burst_index,
  input  logic                        ar_accepted,
  input  logic                        m_axi_rvalid,
  input  logic                        m_axi_rlast,
  input  logic                        m_axis_tready,
  output logic                        ar_stall,
  output logic                        ctrl_done
);

  // Counters and status
  logic [outstanding_cntr_width-1:0] vacancy_cnt;
  logic [burst_cntr_width-1:0]       r_bursts_to_go;
  logic                              r_final_burst;
  logic                              last_beat_xfer;
  logic                              done_r;

  // rready follows tready, so a beat moves when rvalid and tready meet
  assign last_beat_xfer = m_axi_rvalid & m_axis_tready & m_axi_rlast;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding vacancy
  ////////////////////////////////////////////////////////////////////////////

  // Free slots for bursts in flight
  // Same-cycle AR handshake and last beat cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy_cnt <= outstanding_cntr_width'(max_outstanding);
    end else begin
      case ({ar_accepted, last_beat_xfer})
        2'b10:   vacancy_cnt <= vacancy_cnt - 1'b1;
        2'b01:   vacancy_cnt <= vacancy_cnt + 1'b1;
        default: vacancy_cnt <= vacancy_cnt;
      endcase
    end
  end

  // No slot free means no new address
  assign ar_stall = (vacancy_cnt == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Remaining bursts and done
  ////////////////////////////////////////////////////////////////////////////

  // Bursts still to complete after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_bursts_to_go <= '0;
    end else if (burst_start) begin
      r_bursts_to_go <= last_burst_index;
    end else if (last_beat_xfer && !r_final_burst) begin
      r_bursts_to_go <= r_bursts_to_go - 1'b1;
    end
  end

  assign r_final_burst = (r_bursts_to_go == '0);

  // One-cycle pulse after the last beat of the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      done_r <= 1'b0;
    end else begin
      done_r <= last_beat_xfer & r_final_burst;
    end
  end

  assign ctrl_done = done_r;

  // Vacancy stays within the configured limit
  a_vacancy_limit : assert property (@(posedge aclk) disable iff (areset)
    vacancy_cnt <= outstanding_cntr_width'(max_outstanding));

endmodule : r_completion_tracker

// File: source/axi_read_master.sv
////////////////////////////////////////////////////////////////////////////
// AXI4 read master top level
// Request setup, AR burst issue and completion tracking, with the
// R channel passed straight through to an AXI4-Stream output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_read_master
  import axi_read_pkg::*;
(
  input  logic                       aclk,
  input  logic                       areset,

  // Control
  input  logic                       ctrl_start,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size_in_bytes,
  output logic                       ctrl_done,

  // AXI4 read address channel
  output logic                       m_axi_arvalid,
  input  logic                       m_axi_arready,
  output logic [addr_width-1:0]      m_axi_araddr,
  output logic [log_burst_beats-1:0] m_axi_arlen,

  // AXI4 read data channel
  input  logic                       m_axi_rvalid,
  output logic                       m_axi_rready,
  input  logic [data_width-1:0]      m_axi_rdata,
  input  logic                       m_axi_rlast,

  // AXI4-Stream output
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [data_width-1:0]      m_axis_tdata,
  output logic                       m_axis_tlast
);

  // Setup to issuer and tracker
  logic                        burst_start;
  logic [addr_width-1:0]       base_addr;
  logic [burst_cntr_width-1:0] last_burst_index;
  logic [log_burst_beats-1:0]  final_burst_len;

  // Issuer and tracker handshake
  logic ar_accepted;
  logic ar_stall;

  read_request_setup read_request_setup_inst (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .burst_start             (burst_start),
    .base_addr               (base_addr),
    .last_burst_index        (last_burst_index),
    .final_burst_len         (final_burst_len)
  );

  ar_burst_issuer ar_burst_issuer_inst (
    .aclk             (aclk),
    .areset           (areset),
    .burst_start      (burst_start),
    .base_addr        (base_addr),
    .last_burst_index (last_burst_index),
    .final_burst_len  (final_burst_len),
    .ar_stall         (ar_stall),
    .m_axi_arready    (m_axi_arready),
    .m_axi_arvalid    (m_axi_arvalid),
    .m_axi_araddr     (m_axi_araddr),
    .m_axi_arlen      (m_axi_arlen),
    .ar_accepted      (ar_accepted)
  );

  r_completion_tracker r_completion_tracker_inst (
    .aclk             (aclk),
    .areset           (areset),
    .burst_start      (burst_start),
    .last_burst_index (last_burst_index),
    .ar_accepted      (ar_accepted),
    .m_axi_rvalid     (m_axi_rvalid),
    .m_axi_rlast      (m_axi_rlast),
    .m_axis_tready    (m_axis_tready),
    .ar_stall         (ar_stall),
    .ctrl_done        (ctrl_done)
  );

  // R channel to stream, no buffering
  assign m_axis_tvalid = m_axi_rvalid;
  assign m_axis_tdata  = m_axi_rdata;
  assign m_axis_tlast  = m_axi_rlast;
  // Stream back-pressure stalls the slave directly
  assign m_axi_rready  = m_axis_tready;

endmodule : axi_read_master

// File: bench/clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns clock, reset high for the first 16 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_gen (
  output logic aclk,
  output logic areset
);

  // Free-running 125 MHz clock
  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Synchronous reset, released on the 16th rising edge
  initial begin
    areset = 1'b1;
    repeat (16) @(posedge aclk);
    areset <= 1'b0;
  end

endmodule : clock_gen

// File: bench/axi_read_master_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the AXI4 read master
// Stimulus table, AXI slave memory model, stream sink, checks, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_read_master_tb
  import axi_read_pkg::*;
();

  // Table columns are start address, size in bytes, arready delay and tready duty in percent
  localparam int n_rows = 5;
  localparam logic [31:0] row_addr [n_rows] =
    '{32'h0000_1234, 32'h0000_2fff, 32'h0001_0800, 32'h0004_0010, 32'h0010_0abc};
  localparam logic [31:0] row_size [n_rows] = '{10, 1, 1024, 3000, 5000};
  localparam int row_delay [n_rows] = '{0, 1, 2, 0, 3};
  localparam int row_duty [n_rows] = '{100, 50, 80, 25, 60};

  // DUT ports
  logic aclk, areset, ctrl_start, ctrl_done;
  logic [addr_width-1:0] ctrl_addr_offset, m_axi_araddr;
  logic [xfer_size_width-1:0] ctrl_xfer_size_in_bytes;
  logic m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
  logic [log_burst_beats-1:0] m_axi_arlen;
  logic [data_width-1:0] m_axi_rdata, m_axis_tdata;
  logic m_axis_tvalid, m_axis_tready, m_axis_tlast;

  // Row expectations and progress counters
  integer seed = 44730;
  int error_count = 0;
  int errors_before, row, exp_beats, exp_bursts, cur_delay, cur_duty;
  int beat_count, ar_count, tlast_count, done_count, ar_wait, r_beat;
  logic [31:0] exp_base, exp_word, r_addr, rnd;
  logic [7:0] exp_len, r_len;
  logic exp_last, r_active;
  logic [31:0] rq_addr [$];
  logic [7:0] rq_len [$];
  longint watchdog_ns;

  clock_gen clock_gen_inst (.aclk(aclk), .areset(areset));
  axi_read_master axi_read_master_inst (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Slave memory model and stream sink
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      m_axi_arready <= 1'b0;
      m_axi_rvalid  <= 1'b0;
      m_axis_tready <= 1'b0;
      r_active = 1'b0;
      ar_wait  = 0;
    end else begin
      // Each AR handshake steps the address by 1024 and has arlen 255 but for the last
      if (m_axi_arvalid && m_axi_arready) begin
        exp_word = exp_base + 32'(ar_count) * 1024;
        exp_len  = (ar_count == exp_bursts - 1) ? 8'(exp_beats - 1 - 256 * ar_count) : 8'hff;
        if (m_axi_araddr !== exp_word) begin
          $display("Error: m_axi_araddr expected %h got %h", exp_word, m_axi_araddr);
          error_count++;
        end
        if (m_axi_arlen !== exp_len) begin
          $display("Error: m_axi_arlen expected %h got %h", exp_len, m_axi_arlen);
          error_count++;
        end
        $display("  accepted araddr %h arlen %h", m_axi_araddr, m_axi_arlen);
        rq_addr.push_back(m_axi_araddr);
        rq_len.push_back(m_axi_arlen);
        ar_count++;
        ar_wait = 0;
        m_axi_arready <= 1'b0;
      end else if (m_axi_arvalid) begin
        // arready comes after the row's delay
        if (ar_wait >= cur_delay) m_axi_arready <= 1'b1;
        ar_wait++;
      end
      // Stream valid follows R valid and R ready follows stream ready
      if (m_axis_tvalid !== m_axi_rvalid) begin
        $display("Error: m_axis_tvalid expected %h got %h", m_axi_rvalid, m_axis_tvalid);
        error_count++;
      end
      if (m_axi_rready !== m_axis_tready) begin
        $display("Error: m_axi_rready expected %h got %h", m_axis_tready, m_axi_rready);
        error_count++;
      end
      // Each stream beat carries its own byte address as data
      if (m_axis_tvalid && m_axis_tready) begin
        exp_word = exp_base + 32'(beat_count) * 4;
        exp_last = (beat_count % 256 == 255) || (beat_count == exp_beats - 1);
        if (beat_count >= exp_beats) begin
          $display("Error: stream beat %0d arrived beyond the %0d expected", beat_count,
                   exp_beats);
          error_count++;
        end
        if (m_axis_tdata !== exp_word) begin
          $display("Error: m_axis_tdata expected %h got %h", exp_word, m_axis_tdata);
          error_count++;
        end
        if (m_axis_tlast !== exp_last) begin
          $display("Error: m_axis_tlast expected %h got %h", exp_last, m_axis_tlast);
          error_count++;
        end
        if (m_axis_tlast) tlast_count++;
        beat_count++;
      end
      // Bursts in flight
      if (ar_count - tlast_count > 4) begin
        $display("Error: %0d bursts outstanding, limit is 4", ar_count - tlast_count);
        error_count++;
      end
      if (ctrl_done) begin
        if (beat_count != exp_beats) begin
          $display("Error: ctrl_done came after %0d of %0d beats", beat_count, exp_beats);
          error_count++;
        end
        done_count++;
      end
      // A presented R beat holds until rready
      if (m_axi_rvalid && m_axi_rready) begin
        if (r_beat == r_len) r_active = 1'b0;
        r_beat++;
      end
      if (!(m_axi_rvalid && !m_axi_rready)) begin
        if (!r_active && rq_addr.size() > 0) begin
          r_addr   = rq_addr.pop_front();
          r_len    = rq_len.pop_front();
          r_beat   = 0;
          r_active = 1'b1;
        end
        rnd = $random(seed);
        m_axi_rvalid <= r_active && (rnd[2:0] != 3'b000);
        m_axi_rdata  <= r_addr + 32'(r_beat) * 4;
        m_axi_rlast  <= (r_beat == r_len);
      end
      // tready within the row's duty
      rnd = $random(seed);
      m_axis_tready <= (rnd[30:0] % 100) < cur_duty;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size_in_bytes = '0;
    m_axi_arready = 1'b0;
    m_axi_rvalid = 1'b0;
    m_axi_rdata = '0;
    m_axi_rlast = 1'b0;
    m_axis_tready = 1'b0;
    exp_base = '0;
    exp_beats = 0;
    exp_bursts = 0;
    cur_delay = 0;
    cur_duty = 100;
    @(negedge aclk);
    while (areset) @(negedge aclk);
    if (m_axi_arvalid !== 1'b0 || ctrl_done !== 1'b0) begin
      $display("Error: after reset m_axi_arvalid %h ctrl_done %h, expected 0 0",
               m_axi_arvalid, ctrl_done);
      error_count++;
    end
    for (row = 0; row < n_rows; row++) begin
      // Expected shape from the byte count and the 4 KB aligned base
      exp_base   = row_addr[row] & 32'hffff_f000;
      exp_beats  = (row_size[row] + 3) / 4;
      exp_bursts = (exp_beats + 255) / 256;
      cur_delay  = row_delay[row];
      cur_duty   = row_duty[row];
      beat_count = 0;
      ar_count = 0;
      tlast_count = 0;
      done_count = 0;
      errors_before = error_count;
      @(posedge aclk);
      ctrl_start <= 1'b1;
      ctrl_addr_offset <= row_addr[row];
      ctrl_xfer_size_in_bytes <= row_size[row];
      @(posedge aclk);
      ctrl_start <= 1'b0;
      @(negedge aclk);
      while (done_count == 0) @(negedge aclk);
      // Drain time also catches a second done pulse
      repeat (8) @(negedge aclk);
      if (beat_count != exp_beats || ar_count != exp_bursts || done_count != 1) begin
        $display("Error: row %0d gave %0d beats, %0d bursts, %0d done, expected %0d, %0d, 1",
                 row, beat_count, ar_count, done_count, exp_beats, exp_bursts);
        error_count++;
      end
      $display("Row %0d addr %h size %0d: %0d beats, %0d bursts, %0d errors", row,
               row_addr[row], row_size[row], beat_count, ar_count, error_count - errors_before);
    end
    $display("Rows run %0d, errors %0d", n_rows, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the beat counts of the table
  initial begin
    watchdog_ns = 16 * 8;
    for (int i = 0; i < n_rows; i++) begin
      watchdog_ns += ((row_size[i] + 3) / 4 + 64) * 4 * 8;
    end
    #(watchdog_ns);
    $display("Timeout: run did not finish within %0d ns", watchdog_ns);
    $display("Errors found");
    $finish;
  end

endmodule : axi_read_master_tb

// File: axi_read_master.f
source/axi_read_pkg.sv
source/read_request_setup.sv
source/ar_burst_issuer.sv
source/r_completion_tracker.sv
source/axi_read_master.sv
bench/clock_gen.sv
bench/axi_read_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AXI4 read master testbench with Verilator
# The run fails when the log holds the fail message
verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_read_master_tb -f axi_read_master.f &&
  ./obj_dir/Vaxi_read_master_tb > sim.log 2>&1 &&
  cat sim.log &&
  ! grep -q "Errors found" sim.log ||
  { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
